// File: merge_rec_pkg.sv
//////////////////////////////
// Record definitions for the two-way merge unit
// Key and payload widths, the record layout and the queue depth
//////////////////////////////
`default_nettype none

package merge_rec_pkg;

  // Field widths
  localparam int KEY_W = 32;
  localparam int PAY_W = 32;

  // Input queue depth, one block per entry
  localparam int FIFO_LOG   = 4;
  localparam int FIFO_DEPTH = 1 << FIFO_LOG;

  // Largest key, marks the end of a stream
  localparam logic [KEY_W-1:0] KEY_MAX = '1;

  // One record, key in the low bits so block[0] leads on the key
  typedef struct packed {
    logic [PAY_W-1:0] payload;
    logic [KEY_W-1:0] key;
  } record_t;

endpackage

`default_nettype wire

// File: merge_ctrl_pkg.sv
//////////////////////////////
// Control types for the two-way merge unit
// Selector states and queue status
//////////////////////////////
`default_nettype none

package merge_ctrl_pkg;

  // Start-up fill of both sides, then steady merge
  typedef enum logic [1:0] {
    SEL_FILL_A,
    SEL_FILL_B,
    SEL_MERGE
  } sel_state_e;

  // Queue status seen by the selector
  typedef struct packed {
    logic emp;
    logic full;
  } fifo_stat_t;

endpackage

`default_nettype wire

// File: srl_fifo.sv
//////////////////////////////
// Shift-register FIFO
// New entries shift in at slot 0, a head pointer tracks the oldest
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module srl_fifo #(
  parameter int WIDTH = 256
) (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire                        enq,
  input  wire                        deq,
  input  wire  [WIDTH-1:0]           din,
  output logic [WIDTH-1:0]           dout,
  output merge_ctrl_pkg::fifo_stat_t stat
);

  import merge_rec_pkg::*;

  localparam logic [FIFO_LOG:0] CNT_FULL = {1'b1, {FIFO_LOG{1'b0}}};

  logic [WIDTH-1:0]    mem [FIFO_DEPTH];
  logic [FIFO_LOG-1:0] head;  // Slot of the oldest entry
  logic [FIFO_LOG:0]   cnt;

  assign dout = mem[head];

  always_comb begin
    stat.emp  = (cnt == '0);
    stat.full = (cnt == CNT_FULL);
  end

  // Head moves with the shift on enqueue, back on dequeue
  always_ff @(posedge CLK) begin
    if (RST) begin
      cnt  <= '0;
      head <= '1;
    end else begin
      case ({enq, deq})
        2'b10: begin
          cnt  <= cnt + 1'b1;
          head <= head + 1'b1;
        end
        2'b01: begin
          cnt  <= cnt - 1'b1;
          head <= head - 1'b1;
        end
        default: ;  // Both or neither, head stays on the right entry
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (enq) begin
      mem[0] <= din;
      for (int i = 1; i < FIFO_DEPTH; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

endmodule

`default_nettype wire

// File: block_selector.sv
//////////////////////////////
// Block selector
// Fills two blocks per side at start-up, then picks the block with
// the smaller leading key from the two queues each cycle
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module block_selector #(
  parameter int E_LOG = 2
) (
  input  wire                                              CLK,
  input  wire                                              RST,
  input  wire                                              stall,
  input  wire  merge_rec_pkg::record_t [(1<<E_LOG)-1:0]    head_a,
  input  wire  merge_ctrl_pkg::fifo_stat_t                 stat_a,
  input  wire  merge_rec_pkg::record_t [(1<<E_LOG)-1:0]    head_b,
  input  wire  merge_ctrl_pkg::fifo_stat_t                 stat_b,
  output logic                                             deq_a,
  output logic                                             deq_b,
  output merge_rec_pkg::record_t [(1<<E_LOG)-1:0]          sel_blk,
  output logic                                             sel_en
);

  import merge_rec_pkg::*;
  import merge_ctrl_pkg::*;

  localparam int E = 1 << E_LOG;

  typedef record_t [E-1:0] block_t;

  sel_state_e state;
  logic       fill_cnt;  // Second fill dequeue of a side
  logic       choice;    // 1 takes side A
  logic       flip;      // Tie breaker on equal keys

  block_t a0, a1;  // a1 is the older block of A
  block_t b0, b1;

  logic deq_fill_a, deq_fill_b;
  logic deq_mrg_a, deq_mrg_b;
  logic cmp_lt, cmp_eq;

  //////////////////////////////
  // Dequeue requests
  //////////////////////////////
  assign deq_fill_a = (state == SEL_FILL_A) && !stat_a.emp && !stall;
  assign deq_fill_b = (state == SEL_FILL_B) && !stat_b.emp && !stall;
  assign deq_mrg_a  = (state == SEL_MERGE) && choice && !stat_a.emp && !stall;
  assign deq_mrg_b  = (state == SEL_MERGE) && !choice && !stat_b.emp && !stall;

  assign deq_a   = deq_fill_a || deq_mrg_a;
  assign deq_b   = deq_fill_b || deq_mrg_b;
  assign sel_en  = deq_mrg_a || deq_mrg_b;
  assign sel_blk = choice ? a1 : b1;

  //////////////////////////////
  // Two block registers per side
  //////////////////////////////
  always_ff @(posedge CLK) begin
    if (deq_a) begin
      a0 <= head_a;
      a1 <= a0;
    end
  end

  always_ff @(posedge CLK) begin
    if (deq_b) begin
      b0 <= head_b;
      b1 <= b0;
    end
  end

  // After taking A its newer block moves up and faces b1, and the other way round
  always_comb begin
    if (choice) begin
      cmp_lt = (a0[0].key < b1[0].key);
      cmp_eq = (a0[0].key == b1[0].key);
    end else begin
      cmp_lt = (a1[0].key < b0[0].key);
      cmp_eq = (a1[0].key == b0[0].key);
    end
  end

  //////////////////////////////
  // Fill sequence and choice
  //////////////////////////////
  always_ff @(posedge CLK) begin
    if (RST) begin
      state    <= SEL_FILL_A;
      fill_cnt <= 1'b0;
      choice   <= 1'b0;
      flip     <= 1'b0;
    end else begin
      case (state)
        SEL_FILL_A: begin
          if (deq_fill_a) begin
            fill_cnt <= ~fill_cnt;
            if (fill_cnt) state <= SEL_FILL_B;
          end
        end
        SEL_FILL_B: begin
          if (deq_fill_b) begin
            fill_cnt <= ~fill_cnt;
            if (fill_cnt) begin
              state  <= SEL_MERGE;
              choice <= cmp_lt;  // First pick, a1 against the incoming b0
            end
          end
        end
        SEL_MERGE: begin
          if (sel_en) begin
            if (cmp_eq) begin
              choice <= flip;
              flip   <= ~flip;
            end else begin
              choice <= cmp_lt;
            end
          end
        end
        default: state <= SEL_FILL_A;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sort_stage.sv
//////////////////////////////
// Sort stage
// Inserts the feedback record into a sorted block, passes on the E
// smallest records and keeps the largest as the next feedback
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sort_stage #(
  parameter int E_LOG = 2
) (
  input  wire                                           CLK,
  input  wire                                           RST,
  input  wire                                           stall,
  input  wire  merge_rec_pkg::record_t [(1<<E_LOG)-1:0] din,
  input  wire                                           din_en,
  output merge_rec_pkg::record_t [(1<<E_LOG)-1:0]       dout,
  output logic                                          dout_en
);

  import merge_rec_pkg::*;

  localparam int E = 1 << E_LOG;

  //////////////////////////////
  // Stage A
  //////////////////////////////
  record_t [E-1:0] blk_a;
  logic            en_a;
  record_t         fb;    // Feedback record, zero after reset
  logic [E-1:0]    lt_a;  // Record key below feedback key

  always_ff @(posedge CLK) begin
    if (!stall) blk_a <= din;
  end

  always_ff @(posedge CLK) begin
    if (RST) en_a <= 1'b0;
    else if (!stall) en_a <= din_en;
  end

  always_comb begin
    for (int i = 0; i < E; i++) begin
      lt_a[i] = (blk_a[i].key < fb.key);
    end
  end

  // Keep whichever of the last record and the feedback is larger
  always_ff @(posedge CLK) begin
    if (RST) fb <= '0;
    else if (!stall && en_a) fb <= lt_a[E-1] ? fb : blk_a[E-1];
  end

  //////////////////////////////
  // Stage B
  //////////////////////////////
  record_t [E-1:0] blk_b;
  record_t         fb_b;
  logic [E-1:0]    lt_b;
  logic            en_b;

  always_ff @(posedge CLK) begin
    if (!stall) begin
      blk_b <= blk_a;
      fb_b  <= fb;
      lt_b  <= lt_a;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) en_b <= 1'b0;
    else if (!stall) en_b <= en_a;
  end

  // Slot i takes the record below it, the feedback, or its own record
  always_comb begin
    dout[0] = lt_b[0] ? blk_b[0] : fb_b;
    for (int i = 1; i < E; i++) begin
      if (!lt_b[i-1]) dout[i] = blk_b[i-1];
      else if (lt_b[i]) dout[i] = blk_b[i];
      else dout[i] = fb_b;
    end
  end

  assign dout_en = en_b;

endmodule

`default_nettype wire

// File: merge_network.sv
//////////////////////////////
// Merge network
// Chain of E sort stages, drops the block of initial feedback zeros
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module merge_network #(
  parameter int E_LOG = 2
) (
  input  wire                                           CLK,
  input  wire                                           RST,
  input  wire                                           stall,
  input  wire  merge_rec_pkg::record_t [(1<<E_LOG)-1:0] din,
  input  wire                                           din_en,
  output merge_rec_pkg::record_t [(1<<E_LOG)-1:0]       dout,
  output logic                                          dout_en
);

  import merge_rec_pkg::*;

  localparam int E = 1 << E_LOG;

  record_t [E-1:0] chain_blk [E+1];
  logic            chain_en  [E+1];
  logic            ejected;  // Zero block has left the last stage

  assign chain_blk[0] = din;
  assign chain_en[0]  = din_en;

  for (genvar i = 0; i < E; i++) begin : g_stage
    sort_stage #(
      .E_LOG(E_LOG)
    ) u_stage (
      .CLK     (CLK),
      .RST     (RST),
      .stall   (stall),
      .din     (chain_blk[i]),
      .din_en  (chain_en[i]),
      .dout    (chain_blk[i+1]),
      .dout_en (chain_en[i+1])
    );
  end

  always_ff @(posedge CLK) begin
    if (RST) ejected <= 1'b0;
    else if (chain_en[E] && !stall) ejected <= 1'b1;
  end

  assign dout    = chain_blk[E];
  assign dout_en = chain_en[E] && ejected && !stall;

endmodule

`default_nettype wire

// File: merge_unit.sv
//////////////////////////////
// Two-way merge unit
// Two block queues, a selector and an E-stage merge network
// Downstream full is registered into a stall for the whole pipeline
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module merge_unit #(
  parameter int E_LOG = 2
) (
  input  wire                                           CLK,
  input  wire                                           RST,
  input  wire                                           enq_a,
  input  wire  merge_rec_pkg::record_t [(1<<E_LOG)-1:0] din_a,
  input  wire                                           enq_b,
  input  wire  merge_rec_pkg::record_t [(1<<E_LOG)-1:0] din_b,
  input  wire                                           in_full,
  output logic                                          full_a,
  output logic                                          full_b,
  output merge_rec_pkg::record_t [(1<<E_LOG)-1:0]       dout,
  output logic                                          dout_en
);

  import merge_rec_pkg::*;
  import merge_ctrl_pkg::*;

  localparam int E = 1 << E_LOG;

  logic            stall;
  record_t [E-1:0] head_a, head_b;
  fifo_stat_t      stat_a, stat_b;
  logic            deq_a, deq_b;
  record_t [E-1:0] sel_blk;
  logic            sel_en;

  always_ff @(posedge CLK) begin
    if (RST) stall <= 1'b0;
    else stall <= in_full;  // One cycle behind downstream full
  end

  srl_fifo #(.WIDTH(E * $bits(record_t))) fifo_a (
    .CLK(CLK), .RST(RST), .enq(enq_a), .deq(deq_a), .din(din_a), .dout(head_a), .stat(stat_a)
  );

  srl_fifo #(.WIDTH(E * $bits(record_t))) fifo_b (
    .CLK(CLK), .RST(RST), .enq(enq_b), .deq(deq_b), .din(din_b), .dout(head_b), .stat(stat_b)
  );

  block_selector #(.E_LOG(E_LOG)) u_sel (
    .CLK     (CLK),
    .RST     (RST),
    .stall   (stall),
    .head_a  (head_a),
    .stat_a  (stat_a),
    .head_b  (head_b),
    .stat_b  (stat_b),
    .deq_a   (deq_a),
    .deq_b   (deq_b),
    .sel_blk (sel_blk),
    .sel_en  (sel_en)
  );

  merge_network #(.E_LOG(E_LOG)) u_net (
    .CLK(CLK), .RST(RST), .stall(stall),
    .din(sel_blk), .din_en(sel_en), .dout(dout), .dout_en(dout_en)
  );

  assign full_a = stat_a.full;
  assign full_b = stat_b.full;

endmodule

`default_nettype wire

// File: merge_unit_sva.sv
//////////////////////////////
// Merge unit assertions
// Stall, dequeue and enqueue rules, bound into the top level
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module merge_unit_sva (
  input wire CLK,
  input wire RST,
  input wire in_full,
  input wire dout_en,
  input wire enq_a,
  input wire enq_b,
  input wire full_a,
  input wire full_b,
  input wire deq_a,
  input wire deq_b
);

  import merge_rec_pkg::*;

  // Queue occupancy rebuilt from the handshakes alone
  logic [FIFO_LOG:0] occ_a, occ_b;

  always_ff @(posedge CLK) begin
    if (RST) begin
      occ_a <= '0;
      occ_b <= '0;
    end else begin
      if (enq_a && !deq_a) occ_a <= occ_a + 1'b1;
      else if (deq_a && !enq_a) occ_a <= occ_a - 1'b1;
      if (enq_b && !deq_b) occ_b <= occ_b + 1'b1;
      else if (deq_b && !enq_b) occ_b <= occ_b - 1'b1;
    end
  end

  // Registered stall holds the output low in the next cycle
  stall_blocks_out: assert property (@(posedge CLK) disable iff (RST) in_full |=> !dout_en)
    else $error("dout_en high one cycle after in_full");

  no_deq_empty_a: assert property (@(posedge CLK) disable iff (RST) deq_a |-> occ_a != '0)
    else $error("deq_a on an empty FIFO");
  no_deq_empty_b: assert property (@(posedge CLK) disable iff (RST) deq_b |-> occ_b != '0)
    else $error("deq_b on an empty FIFO");

  // Source only looks at full, so a late full shows up here
  no_enq_full_a: assert property (@(posedge CLK) disable iff (RST)
    enq_a |-> occ_a < FIFO_DEPTH)
    else $error("enq_a while FIFO A holds a full queue");
  no_enq_full_b: assert property (@(posedge CLK) disable iff (RST)
    enq_b |-> occ_b < FIFO_DEPTH)
    else $error("enq_b while FIFO B holds a full queue");

endmodule

bind merge_unit merge_unit_sva u_sva (
  .CLK     (CLK),
  .RST     (RST),
  .in_full (in_full),
  .dout_en (dout_en),
  .enq_a   (enq_a),
  .enq_b   (enq_b),
  .full_a  (full_a),
  .full_b  (full_b),
  .deq_a   (deq_a),
  .deq_b   (deq_b)
);

`default_nettype wire

// File: tb_merge_unit.sv
//////////////////////////////
// Testbench for the two-way merge unit
// Two sorted random streams with sentinels, random back-pressure,
// output checked against a sorted key model and a payload table
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_merge_unit;

  import merge_rec_pkg::*;

  localparam int E_LOG        = 2;
  localparam int E            = 1 << E_LOG;
  localparam int N_BLK        = 40;           // Data blocks per side
  localparam int N_TOTAL      = N_BLK + E;    // Plus sentinel blocks
  localparam int BURST_MARGIN = 8;
  localparam int SEND_LIMIT   = 20000;
  localparam int DRAIN_LIMIT  = 2000;
  localparam int DRAIN_EXTRA  = 40;

  typedef record_t [E-1:0] block_t;

  logic   CLK;
  logic   RST;
  logic   enq_a, enq_b, in_full;
  block_t din_a, din_b, dout;
  logic   full_a, full_b, dout_en;

  block_t blk_a [N_TOTAL];
  block_t blk_b [N_TOTAL];

  logic [31:0]      rng_state;
  int               serial;
  logic [KEY_W-1:0] model_keys [$];  // All real keys, ascending
  logic [KEY_W-1:0] key_tab [int];   // Serial to key
  bit               seen [int];
  int               out_cnt;
  logic [KEY_W-1:0] last_key;
  logic             prev_rst, prev_in_full;

  merge_unit #(.E_LOG(E_LOG)) dut0 (
    .CLK     (CLK),
    .RST     (RST),
    .enq_a   (enq_a),
    .din_a   (din_a),
    .enq_b   (enq_b),
    .din_b   (din_b),
    .in_full (in_full),
    .full_a  (full_a),
    .full_b  (full_b),
    .dout    (dout),
    .dout_en (dout_en)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {16'd0, rng_state[31:16]};  // Upper half only
  endfunction

  function automatic logic [PAY_W-1:0] payload_of(input logic [KEY_W-1:0] key, input int ser);
    return {ser[15:0], key[15:0] ^ 16'hc3a5};
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Test stopped at the first error");
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic model_insert(input logic [KEY_W-1:0] key);
    int pos;
    pos = model_keys.size();
    while (pos > 0 && model_keys[pos-1] > key) begin
      pos--;
    end
    model_keys.insert(pos, key);
  endtask

  // Nondecreasing key walk with steps of 0 to 3
  task automatic gen_block(inout logic [KEY_W-1:0] walk, output block_t blk);
    logic [31:0] r;
    for (int j = 0; j < E; j++) begin
      r = next_rand();
      walk = walk + (r % 4);
      serial++;
      blk[j].key     = walk;
      blk[j].payload = payload_of(walk, serial);
      key_tab[serial] = walk;
      model_insert(walk);
    end
  endtask

  function automatic block_t sentinel_block();
    block_t blk;
    for (int j = 0; j < E; j++) begin
      blk[j].key     = KEY_MAX;
      blk[j].payload = '0;
    end
    return blk;
  endfunction

  task automatic check_block(input block_t blk);
    record_t rec;
    int      ser;
    for (int j = 0; j < E; j++) begin
      rec = blk[j];
      if (rec.key != KEY_MAX) begin
        ser = {16'd0, rec.payload[31:16]};
        assert (rec.key >= last_key) else stop_with_error($sformatf(
          "MISMATCH time=%0t signal=dout[%0d].key got=%h exp>=%h", $time, j, rec.key, last_key));
        assert (out_cnt < model_keys.size()) else stop_with_error(
          "More real records came out than were sent");
        assert (rec.key == model_keys[out_cnt]) else stop_with_error($sformatf(
          "MISMATCH time=%0t signal=dout[%0d].key got=%h exp=%h",
          $time, j, rec.key, model_keys[out_cnt]));
        assert (key_tab.exists(ser)) else stop_with_error($sformatf(
          "Output payload %h carries serial %0d that was never sent", rec.payload, ser));
        assert (!seen.exists(ser)) else stop_with_error($sformatf(
          "Record with serial %0d came out twice", ser));
        assert (key_tab[ser] == rec.key) else stop_with_error($sformatf(
          "MISMATCH time=%0t signal=dout[%0d].key got=%h exp=%h",
          $time, j, rec.key, key_tab[ser]));
        assert (rec.payload == payload_of(key_tab[ser], ser)) else stop_with_error($sformatf(
          "MISMATCH time=%0t signal=dout[%0d].payload got=%h exp=%h",
          $time, j, rec.payload, payload_of(key_tab[ser], ser)));
        seen[ser] = 1'b1;
        last_key  = rec.key;
        out_cnt++;
      end
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////
  initial begin : output_monitor
    out_cnt      = 0;
    last_key     = '0;
    prev_rst     = 1'b1;
    prev_in_full = 1'b0;
    forever begin
      @(negedge CLK);  // Outputs settled mid-cycle
      if (RST || prev_rst) begin
        assert (!dout_en) else stop_with_error($sformatf(
          "MISMATCH time=%0t signal=dout_en got=%b exp=0", $time, dout_en));
        assert (!full_a) else stop_with_error($sformatf(
          "MISMATCH time=%0t signal=full_a got=%b exp=0", $time, full_a));
        assert (!full_b) else stop_with_error($sformatf(
          "MISMATCH time=%0t signal=full_b got=%b exp=0", $time, full_b));
      end
      assert (!(prev_in_full && dout_en)) else stop_with_error($sformatf(
        "MISMATCH time=%0t signal=dout_en got=1 exp=0", $time));
      if (dout_en) check_block(dout);
      prev_rst     = RST;
      prev_in_full = in_full;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin : stimulus
    logic [KEY_W-1:0] walk_a, walk_b;
    logic [31:0]      r;
    int               idx_a, idx_b, cyc;
    RST       = 1'b1;
    enq_a     = 1'b0;
    enq_b     = 1'b0;
    din_a     = '0;
    din_b     = '0;
    in_full   = 1'b0;
    rng_state = 32'd36854;
    serial    = 0;
    walk_a    = 1;
    walk_b    = 1;
    idx_a     = 0;
    idx_b     = 0;
    for (int i = 0; i < N_BLK; i++) begin
      gen_block(walk_a, blk_a[i]);
      gen_block(walk_b, blk_b[i]);
    end
    for (int i = N_BLK; i < N_TOTAL; i++) begin
      blk_a[i] = sentinel_block();
      blk_b[i] = sentinel_block();
    end

    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Long in_full burst, queue A must fill up
    in_full = 1'b1;
    next_cycle();
    cyc = 0;
    while (!full_a && cyc < FIFO_DEPTH + BURST_MARGIN) begin
      enq_a = 1'b1;
      din_a = blk_a[idx_a];
      idx_a++;
      next_cycle();
      cyc++;
    end
    enq_a = 1'b0;
    assert (full_a) else stop_with_error("full_a did not rise during the in_full burst");

    // Random enqueues and random back-pressure
    cyc = 0;
    while ((idx_a < N_TOTAL || idx_b < N_TOTAL) && cyc < SEND_LIMIT) begin
      r       = next_rand();
      in_full = (r % 5 == 0);  // About 20 percent
      enq_a   = 1'b0;
      enq_b   = 1'b0;
      r       = next_rand();
      if (idx_a < N_TOTAL && !full_a && r[0]) begin
        enq_a = 1'b1;
        din_a = blk_a[idx_a];
        idx_a++;
      end
      if (idx_b < N_TOTAL && !full_b && r[1]) begin
        enq_b = 1'b1;
        din_b = blk_b[idx_b];
        idx_b++;
      end
      next_cycle();
      cyc++;
    end
    enq_a   = 1'b0;
    enq_b   = 1'b0;
    in_full = 1'b0;
    assert (idx_a == N_TOTAL && idx_b == N_TOTAL) else stop_with_error(
      "Timed out while sending blocks into the queues");

    cyc = 0;
    while (out_cnt < model_keys.size() && cyc < DRAIN_LIMIT) begin
      next_cycle();
      cyc++;
    end
    repeat (DRAIN_EXTRA) next_cycle();  // Catch any extra output

    if (out_cnt != model_keys.size()) begin
      stop_with_error($sformatf("Timed out with %0d of %0d records out",
                                out_cnt, model_keys.size()));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: all.f
merge_rec_pkg.sv
merge_ctrl_pkg.sv
srl_fifo.sv
block_selector.sv
sort_stage.sv
merge_network.sv
merge_unit.sv
merge_unit_sva.sv
tb_merge_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_merge_unit
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
